// File: hw/readback_mux.sv
`timescale 1ns/100ps

module readback_mux #(
  parameter int num_regs  = 3,
  parameter int base_addr = 7
) (
  input  logic                                  rd_req,
  input  regbank_pkg::reg_addr_t                rd_addr,
  input  regbank_pkg::reg_word_t [num_regs-1:0] reg_values,
  output regbank_pkg::reg_word_t                rd_data
);
  import regbank_pkg::*;

  int idx;

  always_comb
  begin
    idx = int'(rd_addr) - base_addr;
    rd_data = unmapped_pattern;
    for (int i = 0; i < num_regs; i++)
      if (idx == i)
        rd_data = reg_values[i];
  end

endmodule

// File: hw/reg_cell.sv
`timescale 1ns/100ps

module reg_cell #(
  parameter regbank_pkg::reg_addr_t cell_addr   = '0,   // address this cell answers to
  parameter regbank_pkg::reg_word_t reset_value = '0
) (
  input  logic                   cs,
  input  logic                   reset,
  input  regbank_pkg::reg_cmd_t  cmd,
  output regbank_pkg::reg_word_t value
);
  import regbank_pkg::*;

  reg_word_t next_value;
  logic      hit;

  assign hit = cmd.valid && cmd.addr == cell_addr;   // strobe addressed to us

  // bitwise update against the current contents
  always_comb
  begin
    case (cmd.op)
      op_write:
        next_value = cmd.data;
      op_set:
        next_value = value | cmd.data;     // ones in data are set
      op_clear:
        next_value = value & ~cmd.data;    // ones in data are cleared
      op_toggle:
        next_value = value ^ cmd.data;     // ones in data flip
      default:
        next_value = value;
    endcase
  end

  always_ff @(posedge cs)
  begin
    if (reset)
      value <= reset_value;
    else if (hit)
      value <= next_value;   // lands the cycle after cmd.valid
  end

endmodule

// File: hw/regbank_pkg.sv
package regbank_pkg;

  // register payload and address
  typedef logic [23:0] reg_word_t;   // every cell carries 24 bits
  typedef logic [4:0]  reg_addr_t;   // 32 addresses, only a few are mapped

  // update operation, frame bits 30..29
  typedef enum logic [1:0] {
    op_write  = 2'd0,   // replace
    op_set    = 2'd1,   // or in
    op_clear  = 2'd2,   // and with inverse
    op_toggle = 2'd3    // xor in
  } reg_op_e;

  // completed write frame, port to cells
  typedef struct packed {
    logic      valid;   // single cycle strobe
    reg_op_e   op;
    reg_addr_t addr;
    reg_word_t data;
  } reg_cmd_t;

  // frame layout, msb first on the wire
  localparam int frame_bits     = 32;   // a complete frame
  localparam int addr_bits_done = 8;    // flag, op and address have arrived
  localparam int dir_pos        = 31;   // direction flag
  localparam int op_pos         = 29;   // lsb of the op field
  localparam int addr_pos       = 24;   // lsb of the address field

  localparam logic dir_write = 1'b0;    // flag value of a write frame

  // where the address sits in the shifter once addr_bits_done bits are in
  localparam int rd_addr_pos = addr_pos - (frame_bits - addr_bits_done);

  // readback of an address with no cell behind it
  localparam reg_word_t unmapped_pattern = 24'h0f0f0f;

endpackage

// File: hw/spi_frame_port.sv
`timescale 1ns/100ps

module spi_frame_port (
  input  logic                   cs,
  input  logic                   reset,
  input  logic                   sclk,
  input  logic                   ss_n,
  input  logic                   mosi,
  output logic                   miso,
  output regbank_pkg::reg_cmd_t  cmd,
  output logic                   rd_req,
  output regbank_pkg::reg_addr_t rd_addr,
  input  regbank_pkg::reg_word_t rd_data
);
  import regbank_pkg::*;

  localparam int cnt_max  = frame_bits + 1;      // count saturates one past a full frame
  localparam int cnt_bits = $clog2(cnt_max + 1);
  localparam int word_bits = $bits(reg_word_t);

  // bit 0 is the first sync stage, bit 1 the synced copy, bit 2 its history
  logic [2:0] sclk_q;
  logic [2:0] ss_q;
  logic [1:0] mosi_q;

  logic sclk_rise;
  logic sclk_fall;
  logic ss_rise;
  logic ss_idle;   // synced chip select high

  logic [cnt_bits-1:0]   bit_cnt;
  logic [frame_bits-1:0] shift_in;
  reg_word_t             shift_out;
  logic                  frame_done;

  // two flop synchronizers, idle levels on reset
  always_ff @(posedge cs)
  begin
    if (reset)
    begin
      sclk_q <= '0;      // mode 0 idles low
      ss_q   <= '1;      // deselected
    end
    else
    begin
      sclk_q <= {sclk_q[1:0], sclk};
      ss_q   <= {ss_q[1:0], ss_n};
    end
  end

  always_ff @(posedge cs)
  begin
    mosi_q <= {mosi_q[0], mosi};  // data line, only sampled on a detected rise
  end

  assign sclk_rise = sclk_q[1] & ~sclk_q[2];
  assign sclk_fall = ~sclk_q[1] & sclk_q[2];
  assign ss_rise   = ss_q[1] & ~ss_q[2];    // end of frame
  assign ss_idle   = ss_q[1];

  // bit counter, cleared between frames
  always_ff @(posedge cs)
  begin
    if (reset)
      bit_cnt <= '0;
    else if (ss_idle)
      bit_cnt <= '0;
    else if (sclk_rise && bit_cnt != cnt_bits'(cnt_max))
      bit_cnt <= bit_cnt + 1'b1;   // stops at 33, marks an overlong frame
  end

  // input shifter, mosi enters at the lsb
  always_ff @(posedge cs)
  begin
    if (ss_idle)
      shift_in <= '0;
    else if (sclk_rise)
      shift_in <= {shift_in[frame_bits-2:0], mosi_q[1]};
  end

  // readback request, one cycle after the rise of bit 8
  always_ff @(posedge cs)
  begin
    if (reset)
      rd_req <= 1'b0;
    else
      rd_req <= sclk_rise && !ss_idle && bit_cnt == cnt_bits'(addr_bits_done - 1);
  end

  // address field is still in the low bits, next rise is several cycles away
  assign rd_addr = shift_in[rd_addr_pos +: $bits(reg_addr_t)];

  // output shifter
  // loaded from the mux while rd_req is high, then moved on each fall
  always_ff @(posedge cs)
  begin
    if (ss_idle)
      shift_out <= '0;
    else if (rd_req)
      shift_out <= rd_data;                              // value bit 23 goes out next fall
    else if (sclk_fall)
      shift_out <= {shift_out[word_bits-2:0], 1'b0};    // zero fill
  end

  always_ff @(posedge cs)
  begin
    if (reset)
      miso <= 1'b0;
    else if (ss_idle)
      miso <= 1'b0;    // quiet while deselected
    else if (sclk_fall)
      miso <= shift_out[word_bits-1];   // host samples on the next rise
  end

  // a write counts only with exactly 32 bits and the flag at write
  assign frame_done = ss_rise && bit_cnt == cnt_bits'(frame_bits)
                   && shift_in[dir_pos] == dir_write;

  // command register, shift_in is cleared on this same edge
  always_ff @(posedge cs)
  begin
    if (reset)
      cmd.valid <= 1'b0;
    else
    begin
      cmd.valid <= frame_done;   // one cycle strobe
      if (frame_done)
      begin
        cmd.op   <= reg_op_e'(shift_in[op_pos +: $bits(reg_op_e)]);
        cmd.addr <= shift_in[addr_pos +: $bits(reg_addr_t)];
        cmd.data <= shift_in[word_bits-1:0];
      end
    end
  end

endmodule

// File: hw/spi_regbank_top.sv
`timescale 1ns/100ps

module spi_regbank_top #(
  parameter int                     num_regs  = 3,
  parameter int                     base_addr = 7,
  parameter regbank_pkg::reg_word_t led_reset = 24'haaaaaa   // test pattern for index 0
) (
  input  logic                                  cs,
  input  logic                                  reset,
  input  logic                                  sclk,
  input  logic                                  ss_n,
  input  logic                                  mosi,
  output logic                                  miso,
  output regbank_pkg::reg_word_t [num_regs-1:0] reg_values
);
  import regbank_pkg::*;

  reg_cmd_t  cmd;       // write strobe to every cell
  logic      rd_req;    // readback request after the address byte
  reg_addr_t rd_addr;
  reg_word_t rd_data;

  // serial side
  spi_frame_port u_port (
    .cs      (cs),
    .reset   (reset),
    .sclk    (sclk),
    .ss_n    (ss_n),
    .mosi    (mosi),
    .miso    (miso),
    .cmd     (cmd),
    .rd_req  (rd_req),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // default map
  // 7 led, 8 spi mux, 9 state of the 4094 shift registers
  for (genvar i = 0; i < num_regs; i++)
  begin : g_cell
    reg_cell #(
      .cell_addr   (reg_addr_t'(base_addr + i)),
      .reset_value ((i == 0) ? led_reset : reg_word_t'(0))   // others start cleared
    ) u_cell (
      .cs    (cs),
      .reset (reset),
      .cmd   (cmd),
      .value (reg_values[i])
    );
  end

  // readback selection, answers in the cycle of rd_req
  readback_mux #(
    .num_regs  (num_regs),
    .base_addr (base_addr)
  ) u_mux (
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .reg_values (reg_values),
    .rd_data    (rd_data)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the register bank testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_spi_regbank \
  -f src.f \
  -Mdir obj_dir

# the simulation output is searched, its exit status alone does not decide
sim_out=$(./obj_dir/Vtb_spi_regbank 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'NO ERRORS'; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: src.f
hw/regbank_pkg.sv
hw/spi_frame_port.sv
hw/reg_cell.sv
hw/readback_mux.sv
hw/spi_regbank_top.sv
verification/regbank_chk.sv
verification/tb_spi_regbank.sv

// File: verification/regbank_chk.sv
`timescale 1ns/100ps

module regbank_chk #(
  parameter int num_regs = 3
) (
  input logic                                  cs,
  input logic                                  reset,
  input logic                                  ss_n,
  input logic                                  miso,
  input regbank_pkg::reg_cmd_t                 cmd,
  input regbank_pkg::reg_word_t [num_regs-1:0] reg_values
);
  int unsigned fail_count = 0;   // read by the testbench at the end of the run

  // write strobe lasts exactly one cycle
  valid_pulse: assert property (@(posedge cs) disable iff (reset)
    cmd.valid |=> !cmd.valid)
  else
  begin
    $error("cmd.valid held high for more than one cycle");
    fail_count++;
  end

  // cells only move in the cycle after a write strobe
  regs_follow_cmd: assert property (@(posedge cs) disable iff (reset)
    reg_values != $past(reg_values) |-> $past(cmd.valid))
  else
  begin
    $error("reg_values changed without a preceding write command");
    fail_count++;
  end

  // synchronizer delay on ss_n, so miso is only required low after three cycles high
  miso_quiet: assert property (@(posedge cs) disable iff (reset)
    ss_n && $past(ss_n) && $past(ss_n, 2) && $past(ss_n, 3) |-> !miso)
  else
  begin
    $error("miso not low while ss_n is high");
    fail_count++;
  end

endmodule

bind spi_regbank_top regbank_chk #(
  .num_regs (num_regs)
) u_chk (
  .cs         (cs),
  .reset      (reset),
  .ss_n       (ss_n),
  .miso       (miso),
  .cmd        (cmd),
  .reg_values (reg_values)
);

// File: verification/tb_spi_regbank.sv
`timescale 1ns/100ps

module tb_spi_regbank;
  import regbank_pkg::*;

  localparam int num_regs    = 3;      // default top
  localparam int base_addr   = 7;
  localparam int half_period = 4;      // cs cycles per sclk half
  localparam int idle_cycles = 8;      // ss_n high after a frame, covers the write latency
  // about 80 frames of roughly 275 cycles each, plus margin
  localparam int timeout_cycles = 30000;

  logic                     cs;
  logic                     reset;
  logic                     sclk;
  logic                     ss_n;
  logic                     mosi;
  logic                     miso;
  reg_word_t [num_regs-1:0] reg_values;

  reg_word_t   model_regs [num_regs];  // expected register contents
  logic [31:0] rx_word;                // miso bits of the last frame, msb first
  reg_word_t   exp_read;               // what the last frame should have read back
  logic        exp_read_valid;         // frame was long enough to carry the value
  int          frames_sent;
  int          frames_checked;
  int          error_count;
  int          check_count;
  int          test_count;
  int          test_errors_start;
  int          cycle_count;
  int          seed;

  spi_regbank_top dut (
    .cs         (cs),
    .reset      (reset),
    .sclk       (sclk),
    .ss_n       (ss_n),
    .mosi       (mosi),
    .miso       (miso),
    .reg_values (reg_values)
  );

  initial
    cs = 1'b0;
  always #20 cs = ~cs;   // 40 ns period

  // reference rules for one register update
  function automatic reg_word_t model_update(reg_word_t old, reg_op_e op, reg_word_t data);
    reg_word_t result;
    case (op)
      op_write:  result = data;           // replace
      op_set:    result = old | data;
      op_clear:  result = old & ~data;
      default:   result = old ^ data;     // toggle
    endcase
    return result;
  endfunction

  // readback prediction, unmapped addresses give the fixed pattern
  function automatic reg_word_t model_read(reg_addr_t addr);
    int idx;
    idx = int'(addr) - base_addr;
    if (idx >= 0 && idx < num_regs)
      return model_regs[idx];
    return 24'h0f0f0f;
  endfunction

  function automatic reg_word_t rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[23:0];
  endfunction

  task automatic check_value(string name, reg_word_t expected, reg_word_t actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("CHECK FAILED %s expected 0x%06h actual 0x%06h", name, expected, actual);
    end
  endtask

  // mode 0 master, data changes while sclk is low, miso taken just before each rise
  task automatic spi_frame(logic [31:0] frame, int nbits);
    logic [31:0] rx;
    rx = '0;
    @(posedge cs);
    ss_n <= 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      mosi <= (i < 32) ? frame[31 - i] : 1'b0;   // bit 33 is filler
      repeat (half_period - 1) @(posedge cs);
      @(negedge cs);
      if (i < 32)
        rx[31 - i] = miso;                       // settled since the last fall
      @(posedge cs);
      sclk <= 1'b1;
      repeat (half_period) @(posedge cs);
      sclk <= 1'b0;
    end
    repeat (half_period) @(posedge cs);
    ss_n <= 1'b1;                                // end of frame
    mosi <= 1'b0;
    repeat (idle_cycles) @(posedge cs);
    rx_word = rx;
  endtask

  // one frame, then the model and a hand-off to the compare process
  task automatic run_frame(logic rd, reg_op_e op, reg_addr_t addr, reg_word_t data, int nbits);
    int idx;
    exp_read = model_read(addr);                 // shifter is loaded before any write lands
    exp_read_valid = nbits >= 32;
    spi_frame({rd, op, addr, data}, nbits);
    idx = int'(addr) - base_addr;
    if (!rd && nbits == 32 && idx >= 0 && idx < num_regs)
      model_regs[idx] = model_update(model_regs[idx], op, data);
    frames_sent++;
    while (frames_checked != frames_sent)
      @(posedge cs);
  endtask

  task automatic read_all();
    for (int i = 0; i < num_regs; i++)
      run_frame(1'b1, op_write, reg_addr_t'(base_addr + i), '0, 32);
  endtask

  task automatic op_test(reg_op_e op);
    for (int i = 0; i < num_regs; i++)
    begin
      run_frame(1'b0, op, reg_addr_t'(base_addr + i), rand_word(), 32);
      run_frame(1'b1, op_write, reg_addr_t'(base_addr + i), '0, 32);   // read back
    end
  endtask

  task automatic start_test();
    test_errors_start = error_count;
  endtask

  task automatic end_test(string name);
    test_count++;
    if (error_count == test_errors_start)
      $display("test %0d %s: ok", test_count, name);
    else
      $display("test %0d %s: %0d errors", test_count, name, error_count - test_errors_start);
  endtask

  // compare process, runs once per finished frame at the falling edge
  always @(negedge cs)
  begin
    if (frames_checked != frames_sent)
    begin
      if (exp_read_valid)
        check_value("miso", exp_read, rx_word[23:0]);
      for (int i = 0; i < num_regs; i++)
        check_value($sformatf("reg_values[%0d]", i), model_regs[i], reg_values[i]);
      frames_checked = frames_checked + 1;
    end
  end

  always @(posedge cs)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles)
    begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial
  begin
    logic [31:0] r;
    int          pick;
    reset = 1'b1;     // inputs at their idle levels
    sclk = 1'b0;
    ss_n = 1'b1;
    mosi = 1'b0;
    seed = 32'hd681;
    cycle_count = 0;
    frames_sent = 0;
    frames_checked = 0;
    error_count = 0;
    check_count = 0;
    test_count = 0;
    exp_read_valid = 1'b0;
    model_regs[0] = 24'haaaaaa;                  // led test pattern
    for (int i = 1; i < num_regs; i++)
      model_regs[i] = '0;

    repeat (5) @(posedge cs);
    reset <= 1'b0;
    repeat (4) @(posedge cs);

    start_test();
    read_all();
    end_test("reset values");

    start_test();
    for (int i = 0; i < num_regs; i++)
      run_frame(1'b0, op_write, reg_addr_t'(base_addr + i), rand_word(), 32);
    read_all();
    end_test("write and read back");

    start_test();
    op_test(op_set);
    op_test(op_clear);
    op_test(op_toggle);
    end_test("set clear toggle");

    start_test();
    run_frame(1'b1, op_write, 5'd0, '0, 32);
    run_frame(1'b1, op_write, 5'd6, '0, 32);     // just below the map
    run_frame(1'b1, op_write, 5'd10, '0, 32);    // just above
    run_frame(1'b1, op_write, 5'd31, '0, 32);
    run_frame(1'b0, op_write, 5'd6, rand_word(), 32);
    run_frame(1'b0, op_toggle, 5'd10, rand_word(), 32);
    end_test("unmapped addresses");

    start_test();
    run_frame(1'b0, op_write, reg_addr_t'(base_addr), rand_word(), 8);
    run_frame(1'b0, op_set, reg_addr_t'(base_addr + 1), rand_word(), 16);
    run_frame(1'b0, op_toggle, reg_addr_t'(base_addr + 2), rand_word(), 31);
    run_frame(1'b0, op_write, reg_addr_t'(base_addr), rand_word(), 33);
    // the held 32 bits of these two decode as a write to address 8
    run_frame(1'b0, op_write, 5'd16, rand_word(), 31);              // fields one place down
    run_frame(1'b0, op_write, 5'd4, rand_word() & 24'h7fffff, 33);  // fields one place up
    read_all();
    end_test("short and long frames");

    start_test();
    for (int n = 0; n < 40; n++)
    begin
      r = $random(seed);
      pick = int'(r[7:0]) % (num_regs + 2);      // one address on each side of the map
      run_frame(r[10], reg_op_e'(r[9:8]), reg_addr_t'(base_addr - 1 + pick), rand_word(), 32);
    end
    end_test("random mix");

    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             test_count, check_count, error_count, dut.u_chk.fail_count);
    if (error_count == 0 && dut.u_chk.fail_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule
